/* src/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // datapath widths
    localparam int XLEN  = 32;
    localparam int TAG_W = 6;                // physical register tag

    // queue sizing and flow control
    localparam int LANE_DEPTH  = 4;          // entries per lane fifo, also input credits
    localparam int CDB_CREDITS = 4;          // result port credits after reset
    localparam int NUM_LANES   = 2;

    // operand / result word
    typedef logic [XLEN-1:0] word_t;

    // destination tag
    typedef logic [TAG_W-1:0] tag_t;

    // which lane a cdb result came from
    typedef logic [$clog2(NUM_LANES)-1:0] lane_id_t;

    // occupancy, must reach LANE_DEPTH itself
    typedef logic [$clog2(LANE_DEPTH+1)-1:0] fifo_cnt_t;

    // output credit count, 0 .. CDB_CREDITS
    typedef logic [$clog2(CDB_CREDITS+1)-1:0] credit_cnt_t;

    // alu operations
    // SLT compares signed, shifts take b[4:0]
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire

/* src/cdb_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cdb_if import exec_pkg::*; ();

    logic  valid;   // lane fifo head holds a result
    tag_t  tag;
    word_t data;
    logic  pop;     // head taken by the arbiter this cycle

    // lane side, result fifo head
    modport lane (
        output valid,
        output tag,
        output data,
        input  pop
    );

    // arbiter side
    modport arb (
        input  valid,
        input  tag,
        input  data,
        output pop
    );

endinterface

`default_nettype wire

/* src/result_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module result_fifo import exec_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,

    input  logic  push_i,
    input  tag_t  push_tag_i,
    input  word_t push_data_i,

    input  logic  pop_i,
    output logic  head_valid_o,
    output tag_t  head_tag_o,
    output word_t head_data_o
);

    tag_t  tag_mem  [LANE_DEPTH];
    word_t data_mem [LANE_DEPTH];

    logic [$clog2(LANE_DEPTH)-1:0] rd_ptr;
    logic [$clog2(LANE_DEPTH)-1:0] wr_ptr;
    fifo_cnt_t                     count;

    // entry storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            tag_mem[wr_ptr]  <= push_tag_i;
            data_mem[wr_ptr] <= push_data_i;
        end
    end

    // pointers wrap at LANE_DEPTH
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == LANE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == LANE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + fifo_cnt_t'(1);
                2'b01:   count <= count - fifo_cnt_t'(1);
                default: count <= count;   // both or neither
            endcase
        end
    end

    assign head_valid_o = (count != '0);
    assign head_tag_o   = tag_mem[rd_ptr];
    assign head_data_o  = data_mem[rd_ptr];

endmodule

`default_nettype wire

/* src/alu_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_lane import exec_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,

    input  logic    valid_i,
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    input  tag_t    tag_i,
    output logic    credit_o,

    cdb_if.lane     cdb
);

    word_t      result;
    logic [4:0] shamt;
    logic       lt_signed;
    logic       credit_q;

    assign shamt     = b_i[4:0];
    assign lt_signed = ($signed(a_i) < $signed(b_i));

    // single cycle alu, result lands in the fifo at the accept edge
    always_comb begin
        case (op_i)
            ADD:     result = a_i + b_i;
            SUB:     result = a_i - b_i;
            AND:     result = a_i & b_i;
            OR:      result = a_i | b_i;
            XOR:     result = a_i ^ b_i;
            SLL:     result = a_i << shamt;
            SRL:     result = a_i >> shamt;
            SLT:     result = {{(XLEN-1){1'b0}}, lt_signed};
            default: result = '0;
        endcase
    end

    // no ready, the sender's credits keep this from overflowing
    result_fifo i_result_fifo (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .push_i       (valid_i),
        .push_tag_i   (tag_i),
        .push_data_i  (result),
        .pop_i        (cdb.pop),
        .head_valid_o (cdb.valid),
        .head_tag_o   (cdb.tag),
        .head_data_o  (cdb.data)
    );

    // one credit back per freed slot, cycle after the pop
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_q <= 1'b0;
        end else begin
            credit_q <= cdb.pop;
        end
    end

    assign credit_o = credit_q;

endmodule

`default_nettype wire

/* src/cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter import exec_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,

    cdb_if.arb       lane0,
    cdb_if.arb       lane1,

    input  logic     credit_i,    // consumer returns one result slot
    output logic     valid_o,
    output lane_id_t lane_o,
    output tag_t     tag_o,
    output word_t    data_o
);

    credit_cnt_t credit_q;
    lane_id_t    last_q;          // lane granted most recently
    lane_id_t    sel;
    logic        has_credit;
    logic        grant;

    assign has_credit = (credit_q != '0);

    // round robin, only matters when both heads are valid
    always_comb begin
        if (lane0.valid && lane1.valid) begin
            sel = ~last_q;
        end else if (lane1.valid) begin
            sel = 1'b1;
        end else begin
            sel = 1'b0;
        end
    end

    assign grant = has_credit && (lane0.valid || lane1.valid);

    assign lane0.pop = grant && (sel == 1'b0);
    assign lane1.pop = grant && (sel == 1'b1);

    // credit spent at grant, the result goes out on the next edge
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_q <= credit_cnt_t'(CDB_CREDITS);
        end else begin
            credit_q <= credit_q - credit_cnt_t'(grant) + credit_cnt_t'(credit_i);
        end
    end

    // last_q starts at 1 so lane 0 wins the first tie
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_q  <= 1'b1;
            valid_o <= 1'b0;
        end else begin
            valid_o <= grant;
            if (grant) begin
                last_q <= sel;
            end
        end
    end

    // result payload
    always_ff @(posedge clk_i) begin
        if (grant) begin
            lane_o <= sel;
            tag_o  <= sel ? lane1.tag  : lane0.tag;
            data_o <= sel ? lane1.data : lane0.data;
        end
    end

endmodule

`default_nettype wire

/* src/exec_cluster_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_top import exec_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,

    // lane 0 issue
    input  logic     in0_valid_i,
    input  alu_op_e  in0_op_i,
    input  word_t    in0_a_i,
    input  word_t    in0_b_i,
    input  tag_t     in0_tag_i,
    output logic     in0_credit_o,

    // lane 1 issue
    input  logic     in1_valid_i,
    input  alu_op_e  in1_op_i,
    input  word_t    in1_a_i,
    input  word_t    in1_b_i,
    input  tag_t     in1_tag_i,
    output logic     in1_credit_o,

    // cdb result port
    output logic     out_valid_o,
    output lane_id_t out_lane_o,
    output tag_t     out_tag_o,
    output word_t    out_data_o,
    input  logic     out_credit_i
);

    cdb_if lane0_cdb ();
    cdb_if lane1_cdb ();

    alu_lane i_alu_lane_0 (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .valid_i  (in0_valid_i),
        .op_i     (in0_op_i),
        .a_i      (in0_a_i),
        .b_i      (in0_b_i),
        .tag_i    (in0_tag_i),
        .credit_o (in0_credit_o),
        .cdb      (lane0_cdb.lane)
    );

    alu_lane i_alu_lane_1 (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .valid_i  (in1_valid_i),
        .op_i     (in1_op_i),
        .a_i      (in1_a_i),
        .b_i      (in1_b_i),
        .tag_i    (in1_tag_i),
        .credit_o (in1_credit_o),
        .cdb      (lane1_cdb.lane)
    );

    // both lanes share one broadcast port
    cdb_arbiter i_cdb_arbiter (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .lane0    (lane0_cdb.arb),
        .lane1    (lane1_cdb.arb),
        .credit_i (out_credit_i),
        .valid_o  (out_valid_o),
        .lane_o   (out_lane_o),
        .tag_o    (out_tag_o),
        .data_o   (out_data_o)
    );

endmodule

`default_nettype wire

/* dv/tb_exec_model.svh */
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

// expected results per lane, oldest at the front
tag_t  exp_tag_q0  [$];
word_t exp_data_q0 [$];
tag_t  exp_tag_q1  [$];
word_t exp_data_q1 [$];

int op_seen [8];    // uses per alu op

// reference alu, built from the op definitions
function automatic word_t ref_alu(input alu_op_e op, input word_t a, input word_t b);
    int unsigned sh;
    word_t       r;
    sh = b & 32'h1f;    // shift amount from b[4:0]
    case (op)
        ADD: r = a + b;
        SUB: r = a + ~b + 1;   // two's complement subtract
        AND: r = a & b;
        OR:  r = a | b;
        XOR: r = a ^ b;
        SLL: r = a << sh;
        SRL: r = a >> sh;
        SLT: begin
            // differing signs, the negative one is smaller
            if (a[XLEN-1] != b[XLEN-1]) begin
                r = word_t'(a[XLEN-1]);
            end else begin
                r = (a < b) ? word_t'(1) : word_t'(0);
            end
        end
        default: r = '0;
    endcase
    return r;
endfunction

// record an accepted instruction
task automatic expect_result(input int lane, input alu_op_e op, input word_t a,
                             input word_t b, input tag_t tag);
    word_t d;
    d = ref_alu(op, a, b);
    op_seen[int'(op)]++;
    if (lane == 0) begin
        exp_tag_q0.push_back(tag);
        exp_data_q0.push_back(d);
    end else begin
        exp_tag_q1.push_back(tag);
        exp_data_q1.push_back(d);
    end
endtask

// oldest outstanding result of a lane
task automatic pop_expected(input int lane, output tag_t tag, output word_t data,
                            output bit found);
    found = 1'b0;
    tag   = '0;
    data  = '0;
    if (lane == 0 && exp_tag_q0.size() > 0) begin
        tag   = exp_tag_q0.pop_front();
        data  = exp_data_q0.pop_front();
        found = 1'b1;
    end else if (lane == 1 && exp_tag_q1.size() > 0) begin
        tag   = exp_tag_q1.pop_front();
        data  = exp_data_q1.pop_front();
        found = 1'b1;
    end
endtask

`endif

/* dv/tb_exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster import exec_pkg::*; ();

    localparam int NUM_INSTR   = 400;                  // per lane
    localparam int TOTAL_INSTR = NUM_INSTR * NUM_LANES;
    localparam int CYCLE_LIMIT = 20 * TOTAL_INSTR;
    localparam int HOLD_START  = 300;                  // output credits withheld from here
    localparam int HOLD_END    = 380;

    logic     clk_i;
    logic     rst_i;
    logic     in0_valid_i;
    alu_op_e  in0_op_i;
    word_t    in0_a_i;
    word_t    in0_b_i;
    tag_t     in0_tag_i;
    logic     in0_credit_o;
    logic     in1_valid_i;
    alu_op_e  in1_op_i;
    word_t    in1_a_i;
    word_t    in1_b_i;
    tag_t     in1_tag_i;
    logic     in1_credit_o;
    logic     out_valid_o;
    lane_id_t out_lane_o;
    tag_t     out_tag_o;
    word_t    out_data_o;
    logic     out_credit_i;

    int lane_credit [NUM_LANES];   // sender side input credits
    int sent_cnt    [NUM_LANES];
    int results    = 0;
    int held       = 0;            // results not yet credited back
    int cycle_cnt  = 0;
    bit stalled    = 1'b0;         // dut output counter is at zero
    bit stall_seen = 1'b0;
    bit done       = 1'b0;

    `include "tb_exec_model.svh"

    exec_cluster_top dut_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .in0_valid_i  (in0_valid_i),
        .in0_op_i     (in0_op_i),
        .in0_a_i      (in0_a_i),
        .in0_b_i      (in0_b_i),
        .in0_tag_i    (in0_tag_i),
        .in0_credit_o (in0_credit_o),
        .in1_valid_i  (in1_valid_i),
        .in1_op_i     (in1_op_i),
        .in1_a_i      (in1_a_i),
        .in1_b_i      (in1_b_i),
        .in1_tag_i    (in1_tag_i),
        .in1_credit_o (in1_credit_o),
        .out_valid_o  (out_valid_o),
        .out_lane_o   (out_lane_o),
        .out_tag_o    (out_tag_o),
        .out_data_o   (out_data_o),
        .out_credit_i (out_credit_i)
    );

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    task automatic error_stop(input string msg);
        $display("ERR @%0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic run_fail(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_data(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            error_stop($sformatf("%s data %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_tag(input tag_t got, input tag_t exp, input string what);
        if (got !== exp) begin
            error_stop($sformatf("%s tag %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_count(input fifo_cnt_t got, input fifo_cnt_t exp, input string what);
        if (got !== exp) begin
            error_stop($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic drive_lane(input int lane, input logic v, input alu_op_e op,
                              input word_t a, input word_t b, input tag_t tag);
        if (lane == 0) begin
            in0_valid_i = v;
            in0_op_i    = op;
            in0_a_i     = a;
            in0_b_i     = b;
            in0_tag_i   = tag;
        end else begin
            in1_valid_i = v;
            in1_op_i    = op;
            in1_a_i     = a;
            in1_b_i     = b;
            in1_tag_i   = tag;
        end
    endtask

    // new instructions and output credits for the next edge
    task automatic drive_inputs();
        logic    send;
        logic    ret;
        logic    withhold;
        alu_op_e op;
        word_t   a;
        word_t   b;
        tag_t    tag;
        for (int l = 0; l < NUM_LANES; l++) begin
            send = (lane_credit[l] > 0) && (sent_cnt[l] < NUM_INSTR) && ($urandom_range(3) != 0);
            op   = ADD;
            a    = '0;
            b    = '0;
            tag  = '0;
            if (send) begin
                op  = alu_op_e'($urandom_range(7));
                a   = $urandom();
                b   = ($urandom_range(7) == 0) ? a : $urandom();   // equal operands for slt
                tag = tag_t'($urandom());
                expect_result(l, op, a, b, tag);
                lane_credit[l]--;
                sent_cnt[l]++;
            end
            drive_lane(l, send, op, a, b, tag);
        end
        withhold = (cycle_cnt >= HOLD_START) && (cycle_cnt < HOLD_END);
        ret = (held > 0) && !withhold && ($urandom_range(2) != 0);
        out_credit_i = ret;
        if (ret) begin
            held--;
        end
    endtask

    task automatic sample_outputs();
        tag_t  exp_tag;
        word_t exp_data;
        bit    found;
        if (in0_credit_o) begin
            lane_credit[0]++;
        end
        if (in1_credit_o) begin
            lane_credit[1]++;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (lane_credit[l] > LANE_DEPTH) begin
                error_stop($sformatf("lane %0d holds %0d input credits", l, lane_credit[l]));
            end
        end
        if (out_valid_o) begin
            if (stalled) begin
                error_stop("result sent while output credits were exhausted");
            end
            pop_expected(int'(out_lane_o), exp_tag, exp_data, found);
            if (!found) begin
                run_fail($sformatf("unexpected result on lane %0d, none outstanding",
                                   out_lane_o));
            end
            check_tag(out_tag_o, exp_tag, $sformatf("lane %0d", out_lane_o));
            check_data(out_data_o, exp_data, $sformatf("lane %0d", out_lane_o));
            results++;
            held++;
        end
        stalled = (held == CDB_CREDITS);
        if (stalled) begin
            stall_seen = 1'b1;
        end
    endtask

    // run limit
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            run_fail($sformatf("run timed out after %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        void'($urandom(32'hfbb));
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_credit[l] = LANE_DEPTH;
            sent_cnt[l]    = 0;
        end
        rst_i        = 1'b1;
        out_credit_i = 1'b0;
        drive_lane(0, 1'b0, ADD, '0, '0, '0);
        drive_lane(1, 1'b0, ADD, '0, '0, '0);
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // idle after reset
        repeat (4) begin
            @(posedge clk_i);
            #1;
            if (out_valid_o !== 1'b0 || in0_credit_o !== 1'b0 || in1_credit_o !== 1'b0) begin
                error_stop("output active after reset with no input");
            end
        end

        while (!done) begin
            drive_inputs();
            @(posedge clk_i);
            #1;
            sample_outputs();
            done = (sent_cnt[0] == NUM_INSTR) && (sent_cnt[1] == NUM_INSTR) &&
                   (results == TOTAL_INSTR) && (held == 0);
        end
        out_credit_i = 1'b0;
        drive_lane(0, 1'b0, ADD, '0, '0, '0);
        drive_lane(1, 1'b0, ADD, '0, '0, '0);

        // nothing may follow the last result
        repeat (4) begin
            @(posedge clk_i);
            #1;
            if (out_valid_o !== 1'b0 || in0_credit_o !== 1'b0 || in1_credit_o !== 1'b0) begin
                run_fail("dut still active after all results arrived");
            end
        end

        for (int l = 0; l < NUM_LANES; l++) begin
            check_count(fifo_cnt_t'(lane_credit[l]), fifo_cnt_t'(LANE_DEPTH),
                        $sformatf("lane %0d input credits", l));
        end
        if (!stall_seen) begin
            run_fail("output credits never ran out during the run");
        end
        for (int i = 0; i < 8; i++) begin
            if (op_seen[i] == 0) begin
                run_fail($sformatf("alu op %0d was never sent", i));
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+dv
src/exec_pkg.sv
src/cdb_if.sv
src/result_fifo.sv
src/alu_lane.sv
src/cdb_arbiter.sv
src/exec_cluster_top.sv
dv/tb_exec_cluster.sv

/* Bender.yml */
package:
  name: exec_cluster

sources:
  - files:
      - src/exec_pkg.sv
      - src/cdb_if.sv
      - src/result_fifo.sv
      - src/alu_lane.sv
      - src/cdb_arbiter.sv
      - src/exec_cluster_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_exec_cluster.sv
